// ==== hw/store_buffer_pkg.sv ====
`default_nettype none

package store_buffer_pkg;

  localparam int ADDR_W      = 32;              // Byte address.
  localparam int WORD_ADDR_W = ADDR_W - 2;      // Word address, byte offset dropped.
  localparam int DATA_W      = 32;
  localparam int MASK_W      = 4;               // One bit per byte lane.
  localparam int ENTRY_W     = WORD_ADDR_W + MASK_W + DATA_W;

  // Entry layout, data low, then mask, then word address.
  localparam int ENTRY_DATA_LSB = 0;
  localparam int ENTRY_MASK_LSB = ENTRY_DATA_LSB + DATA_W;
  localparam int ENTRY_ADDR_LSB = ENTRY_MASK_LSB + MASK_W;

  typedef logic [ADDR_W-1:0]      byte_addr_t;
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;
  typedef logic [DATA_W-1:0]      word_t;
  typedef logic [MASK_W-1:0]      byte_mask_t;
  typedef logic [ENTRY_W-1:0]     entry_t;

  typedef logic [1:0] size_t;
  localparam size_t SIZE_BYTE = 2'd0;
  localparam size_t SIZE_HALF = 2'd1;
  localparam size_t SIZE_WORD = 2'd2;           // Code 3 is handled as a word.

  typedef enum logic {
    DRAIN_IDLE,                                 // Waiting for a head entry.
    DRAIN_BUSY                                  // Write issued, waiting for done.
  } drain_state_t;

  // Halfwords need an even address, words a multiple of four.
  function automatic logic is_misaligned(size_t size, logic [1:0] offset);
    case (size)
      SIZE_BYTE: return 1'b0;
      SIZE_HALF: return offset[0];
      default:   return |offset;
    endcase
  endfunction

  // Byte lanes touched by an aligned access.
  function automatic byte_mask_t lane_mask(size_t size, logic [1:0] offset);
    byte_mask_t base;
    case (size)
      SIZE_BYTE: base = 4'b0001;
      SIZE_HALF: base = 4'b0011;
      default:   base = 4'b1111;
    endcase
    return base << offset;                      // Move to the addressed lane.
  endfunction

endpackage

`default_nettype wire

// ==== hw/fifo_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_sync #(
  parameter int DEPTH = 4,                      // 2, 4, 8 or 16.
  parameter int WIDTH = 32
) (
  input  wire logic             clk,
  input  wire logic             rest,
  input  wire logic             flush,
  input  wire logic             write,
  input  wire logic             read,
  input  wire logic [WIDTH-1:0] write_data,
  output logic                  full,
  output logic                  empty,
  output logic                  half,
  output logic [WIDTH-1:0]      read_data,
  output logic [WIDTH-1:0]      all_data [DEPTH-1:0],
  output logic [DEPTH-1:0]      slot_valid
);

  localparam int PTR_W = $clog2(DEPTH) + 1;     // Extra bit tells full from empty.
  localparam int IDX_W = PTR_W - 1;

  logic [WIDTH-1:0] mem [DEPTH-1:0];
  logic [PTR_W-1:0] front;                      // Read pointer.
  logic [PTR_W-1:0] rear;                       // Write pointer.
  logic [PTR_W-1:0] count;
  logic             do_write;
  logic             do_read;

  assign count = rear - front;
  assign empty = (front == rear);
  // Same index, other lap. A read in this cycle frees a slot for the write.
  assign full  = (front[PTR_W-1] != rear[PTR_W-1]) &&
                 (front[IDX_W-1:0] == rear[IDX_W-1:0]) && !read;
  assign half  = (count >= PTR_W'(DEPTH / 2));

  assign do_write = write && !full;             // Write while full is dropped.
  assign do_read  = read && !empty;             // Pop on empty is dropped.

  assign read_data = mem[front[IDX_W-1:0]];     // Head entry.

  // Pointers. Flush wins over both write and read.
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      front <= '0;
      rear  <= '0;
    end else if (flush) begin
      front <= '0;
      rear  <= '0;
    end else begin
      if (do_write) rear <= rear + 1'b1;
      if (do_read) front <= front + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) mem[rear[IDX_W-1:0]] <= write_data;
  end

  // All slots out, for lookups over the whole buffer.
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      all_data[i] = mem[i];
    end
  end

  // A slot holds live data when it lies between read and write pointer.
  always_comb begin
    logic [IDX_W-1:0] offset;
    offset = '0;
    for (int i = 0; i < DEPTH; i++) begin
      offset        = IDX_W'(i) - front[IDX_W-1:0];  // Distance from head, mod DEPTH.
      slot_valid[i] = ({1'b0, offset} < count);
    end
  end

endmodule

`default_nettype wire

// ==== hw/store_accept.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_accept (
  input  wire logic                        store_valid,
  input  wire store_buffer_pkg::byte_addr_t store_addr,
  input  wire store_buffer_pkg::size_t      store_size,
  input  wire store_buffer_pkg::word_t      store_data,
  input  wire logic                        full,
  output logic                             store_ready,
  output logic                             store_misaligned,
  output logic                             entry_write,
  output store_buffer_pkg::entry_t         entry_data
);

  import store_buffer_pkg::*;

  logic [1:0] offset;                           // Byte offset within the word.
  logic       misaligned;
  byte_mask_t mask;
  word_t      lane_data;
  word_addr_t word_addr;

  assign offset    = store_addr[1:0];
  assign word_addr = store_addr[ADDR_W-1:2];

  assign misaligned = is_misaligned(store_size, offset);
  assign mask       = lane_mask(store_size, offset);
  assign lane_data  = store_data << {offset, 3'b000};  // Offset times 8.

  // Core may strobe only while there is room.
  assign store_ready = !full;

  // Flag lasts exactly the strobe cycle.
  assign store_misaligned = store_valid && misaligned;
  assign entry_write      = store_valid && !misaligned;

  // Pack the entry fields.
  always_comb begin
    entry_data = '0;
    entry_data[ENTRY_ADDR_LSB +: WORD_ADDR_W] = word_addr;
    entry_data[ENTRY_MASK_LSB +: MASK_W]      = mask;
    entry_data[ENTRY_DATA_LSB +: DATA_W]      = lane_data;
  end

endmodule

`default_nettype wire

// ==== hw/load_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_forward #(
  parameter int DEPTH = 4
) (
  input  wire store_buffer_pkg::byte_addr_t load_addr,
  input  wire store_buffer_pkg::size_t      load_size,
  input  wire store_buffer_pkg::entry_t     all_data [DEPTH-1:0],
  input  wire logic [DEPTH-1:0]            slot_valid,
  output logic                             load_conflict,
  output logic                             load_hit,
  output store_buffer_pkg::word_t          load_data
);

  import store_buffer_pkg::*;

  localparam int CNT_W = $clog2(DEPTH + 1);    // Holds 0 to DEPTH.

  byte_mask_t       load_mask;
  word_addr_t       load_word;
  logic [DEPTH-1:0] match;                      // Entry overlaps the load.
  logic [CNT_W-1:0] match_count;
  byte_mask_t       match_mask;                 // Union of matching masks.
  word_t            match_data;                 // Union of matching data.

  assign load_word = load_addr[ADDR_W-1:2];

  // A misaligned load touches no lane, so it never conflicts.
  assign load_mask = is_misaligned(load_size, load_addr[1:0]) ? '0 :
                     lane_mask(load_size, load_addr[1:0]);

  // Compare the load against every live slot.
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      match[i] = slot_valid[i] &&
                 (all_data[i][ENTRY_ADDR_LSB +: WORD_ADDR_W] == load_word) &&
                 |(all_data[i][ENTRY_MASK_LSB +: MASK_W] & load_mask);
    end
  end

  // Count matches and merge their fields. One match leaves just its own.
  always_comb begin
    match_count = '0;
    match_mask  = '0;
    match_data  = '0;
    for (int i = 0; i < DEPTH; i++) begin
      match_count = match_count + CNT_W'(match[i]);
      match_mask  = match_mask | ({MASK_W{match[i]}} & all_data[i][ENTRY_MASK_LSB +: MASK_W]);
      match_data  = match_data | ({DATA_W{match[i]}} & all_data[i][ENTRY_DATA_LSB +: DATA_W]);
    end
  end

  assign load_conflict = (match_count != '0);

  // Forward only from a single entry that covers every load byte.
  assign load_hit  = (match_count == CNT_W'(1)) && ((match_mask & load_mask) == load_mask);
  assign load_data = load_hit ? match_data : '0;

endmodule

`default_nettype wire

// ==== hw/store_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_drain (
  input  wire logic                    clk,
  input  wire logic                    rest,
  input  wire logic                    empty,
  input  wire store_buffer_pkg::entry_t read_data,
  input  wire logic                    mem_done,
  input  wire logic                    flush,
  output logic                         read,
  output logic                         mem_write,
  output store_buffer_pkg::word_addr_t mem_addr,
  output store_buffer_pkg::byte_mask_t mem_mask,
  output store_buffer_pkg::word_t      mem_data
);

  import store_buffer_pkg::*;

  drain_state_t state;
  entry_t       head_q;                         // Entry being written.
  logic         issue;

  // Start a write when idle with a head entry and no flush.
  assign issue = (state == DRAIN_IDLE) && !empty && !flush;

  // Done pops the head in the same cycle. Ignored when idle.
  assign read = (state == DRAIN_BUSY) && mem_done;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state     <= DRAIN_IDLE;
      mem_write <= 1'b0;
    end else begin
      mem_write <= 1'b0;                        // Strobe lasts one cycle.
      case (state)
        DRAIN_IDLE: begin
          if (issue) begin
            state     <= DRAIN_BUSY;
            mem_write <= 1'b1;
          end
        end
        DRAIN_BUSY: begin
          if (mem_done) state <= DRAIN_IDLE;    // Back to idle at the pop.
        end
        default: state <= DRAIN_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) head_q <= read_data;             // Latch head at issue.
  end

  assign mem_addr = head_q[ENTRY_ADDR_LSB +: WORD_ADDR_W];
  assign mem_mask = head_q[ENTRY_MASK_LSB +: MASK_W];
  assign mem_data = head_q[ENTRY_DATA_LSB +: DATA_W];

endmodule

`default_nettype wire

// ==== hw/store_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_buffer_top #(
  parameter int DEPTH = 4                       // 2, 4, 8 or 16 entries.
) (
  input  wire logic                        clk,
  input  wire logic                        rest,
  input  wire logic                        flush,
  input  wire logic                        store_valid,
  input  wire store_buffer_pkg::byte_addr_t store_addr,
  input  wire store_buffer_pkg::size_t      store_size,
  input  wire store_buffer_pkg::word_t      store_data,
  output logic                             store_ready,
  output logic                             store_misaligned,
  input  wire store_buffer_pkg::byte_addr_t load_addr,
  input  wire store_buffer_pkg::size_t      load_size,
  output logic                             load_conflict,
  output logic                             load_hit,
  output store_buffer_pkg::word_t          load_data,
  output logic                             mem_write,
  output store_buffer_pkg::word_addr_t     mem_addr,
  output store_buffer_pkg::byte_mask_t     mem_mask,
  output store_buffer_pkg::word_t          mem_data,
  input  wire logic                        mem_done
);

  import store_buffer_pkg::*;

  logic             full;
  logic             empty;
  logic             entry_write;
  entry_t           entry_data;                 // Aligned store into the FIFO.
  logic             read;                       // Pop from the drain.
  entry_t           head_entry;
  entry_t           all_data [DEPTH-1:0];
  logic [DEPTH-1:0] slot_valid;

  store_accept u_accept (
    .store_valid      (store_valid),
    .store_addr       (store_addr),
    .store_size       (store_size),
    .store_data       (store_data),
    .full             (full),
    .store_ready      (store_ready),
    .store_misaligned (store_misaligned),
    .entry_write      (entry_write),
    .entry_data       (entry_data)
  );

  fifo_sync #(
    .DEPTH (DEPTH),
    .WIDTH (ENTRY_W)
  ) u_fifo (
    .clk        (clk),
    .rest       (rest),
    .flush      (flush),
    .write      (entry_write),
    .read       (read),
    .write_data (entry_data),
    .full       (full),
    .empty      (empty),
    .half       (),                             // Not needed here.
    .read_data  (head_entry),
    .all_data   (all_data),
    .slot_valid (slot_valid)
  );

  load_forward #(
    .DEPTH (DEPTH)
  ) u_lookup (
    .load_addr     (load_addr),
    .load_size     (load_size),
    .all_data      (all_data),
    .slot_valid    (slot_valid),
    .load_conflict (load_conflict),
    .load_hit      (load_hit),
    .load_data     (load_data)
  );

  store_drain u_drain (
    .clk       (clk),
    .rest      (rest),
    .empty     (empty),
    .read_data (head_entry),
    .mem_done  (mem_done),
    .flush     (flush),
    .read      (read),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_mask  (mem_mask),
    .mem_data  (mem_data)
  );

endmodule

`default_nettype wire

// ==== tb/store_buffer_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_buffer_assertions (
  input wire logic clk,
  input wire logic rest,
  input wire logic mem_write,
  input wire logic empty,
  input wire logic all_live,
  input wire logic read,
  input wire logic store_ready
);

  // Memory strobe is a single-cycle pulse.
  a_write_pulse: assert property (@(posedge clk) disable iff (!rest)
    mem_write |=> !mem_write)
    else $error("mem_write stayed high for more than one cycle");

  // A write always has its entry still in the FIFO.
  a_write_not_empty: assert property (@(posedge clk) disable iff (!rest)
    mem_write |-> !empty)
    else $error("mem_write raised while the buffer is empty");

  // Every slot live and no pop this cycle, so no room.
  a_ready_full: assert property (@(posedge clk) disable iff (!rest)
    (all_live && !read) |-> !store_ready)
    else $error("store_ready high while the FIFO is full");

endmodule

bind store_buffer_top store_buffer_assertions u_assertions (
  .clk         (clk),
  .rest        (rest),
  .mem_write   (mem_write),
  .empty       (empty),                         // FIFO flags inside the top level.
  .all_live    (&slot_valid),
  .read        (read),
  .store_ready (store_ready)
);

`default_nettype wire

// ==== tb/store_buffer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_buffer_tb;

  import store_buffer_pkg::*;

  localparam int DEPTH  = 4;
  localparam int CYCLES = 3000;                 // Random stimulus length.
  localparam int DRAIN_LIMIT = 500;             // Cycles allowed to empty the buffer.

  logic       clk = 1'b0;
  logic       rest = 1'b0;
  logic       flush = 1'b0;
  logic       store_valid = 1'b0;
  byte_addr_t store_addr = '0;
  size_t      store_size = '0;
  word_t      store_data = '0;
  logic       store_ready;
  logic       store_misaligned;
  byte_addr_t load_addr = '0;
  size_t      load_size = '0;
  logic       load_conflict;
  logic       load_hit;
  word_t      load_data;
  logic       mem_write;
  word_addr_t mem_addr;
  byte_mask_t mem_mask;
  word_t      mem_data;
  logic       mem_done = 1'b0;

  entry_t     model_q [$];                      // Entries not yet popped, oldest first.
  logic       model_busy = 1'b0;                // Drain has a write out.
  logic       exp_write = 1'b0;                 // mem_write expected this cycle.
  entry_t     exp_head = '0;
  logic       orphan = 1'b0;                    // Write out that a flush overtook.
  logic       resp_pending = 1'b0;
  int         resp_wait = 0;
  logic       saw_write;                        // mem_write seen at last negedge.
  byte_addr_t last_addr = 32'h100;
  int         errors = 0;
  int         writes = 0;
  logic       timed_out = 1'b0;

  store_buffer_top #(.DEPTH(DEPTH)) UUT (.*);

  always #5 clk = ~clk;

  // Halfwords on even addresses, words on multiples of four.
  function automatic logic bad_align(size_t size, logic [1:0] off);
    if (size == 2'd0) return 1'b0;
    if (size == 2'd1) return off[0];
    return off != 2'b00;
  endfunction

  // Lanes an access covers; none when misaligned.
  function automatic byte_mask_t bytes_touched(size_t size, logic [1:0] off);
    byte_mask_t m;
    m = (size == 2'd0) ? 4'b0001 : (size == 2'd1) ? 4'b0011 : 4'b1111;
    if (bad_align(size, off)) m = 4'b0000;
    return m << off;
  endfunction

  // Mostly aligned offsets, some misaligned ones.
  function automatic logic [1:0] pick_offset(size_t size);
    logic [1:0] off;
    off = 2'($urandom);
    if ($urandom % 4 != 0) begin
      if (size == 2'd1) off[0] = 1'b0;
      if (size[1]) off = 2'b00;                 // Codes 2 and 3 are words.
    end
    return off;
  endfunction

  task automatic report(string msg);
    $display("error %0t: %s", $time, msg);
    errors++;
  endtask

  // Compare all outputs against the model queue, mid-cycle.
  task automatic check_outputs();
    int         hits;
    byte_mask_t lm;
    entry_t     found;
    logic       exp_hit;
    logic       exp_ready;
    logic       exp_mis;
    hits  = 0;
    found = '0;
    lm    = bytes_touched(load_size, load_addr[1:0]);
    foreach (model_q[i]) begin
      if (model_q[i][65:36] == load_addr[31:2] && (model_q[i][35:32] & lm) != 4'b0000) begin
        hits++;
        found = model_q[i];
      end
    end
    exp_hit   = (hits == 1) && ((found[35:32] & lm) == lm);
    exp_ready = !(model_q.size() == DEPTH && !(model_busy && mem_done));  // Pop frees a slot.
    exp_mis   = store_valid && bad_align(store_size, store_addr[1:0]);
    if (load_conflict !== (hits > 0))
      report($sformatf("load_conflict %b, expected %b", load_conflict, hits > 0));
    if (load_hit !== exp_hit)
      report($sformatf("load_hit %b, expected %b", load_hit, exp_hit));
    if (load_data !== (exp_hit ? found[31:0] : 32'h0))
      report($sformatf("load_data %h, expected %h", load_data, exp_hit ? found[31:0] : 32'h0));
    if (store_ready !== exp_ready)
      report($sformatf("store_ready %b, expected %b", store_ready, exp_ready));
    if (store_misaligned !== exp_mis)
      report($sformatf("store_misaligned %b, expected %b", store_misaligned, exp_mis));
    if (mem_write !== exp_write)
      report($sformatf("mem_write %b, expected %b", mem_write, exp_write));
    else if (exp_write && {mem_addr, mem_mask, mem_data} !== exp_head)
      report($sformatf("memory write %h/%b/%h, expected %h", mem_addr, mem_mask, mem_data,
                       exp_head));
  endtask

  always @(negedge clk) begin
    saw_write = mem_write;
    if (mem_write === 1'b1) writes++;
    check_outputs();
  end

  // Advance the model across one rising edge, from the values of the cycle before it.
  task automatic advance_model();
    logic pop;
    logic issue;
    logic full;
    pop   = model_busy && mem_done;
    issue = !model_busy && model_q.size() > 0 && !flush;
    full  = model_q.size() == DEPTH && !pop;
    exp_write = issue;
    if (issue) exp_head = model_q[0];           // Head latched by the drain.
    if (pop) begin
      model_busy = 1'b0;
      orphan     = 1'b0;
      if (model_q.size() > 0) void'(model_q.pop_front());
    end
    if (issue) model_busy = 1'b1;
    if (store_valid && !bad_align(store_size, store_addr[1:0]) && !full)
      model_q.push_back({store_addr[31:2], bytes_touched(store_size, store_addr[1:0]),
                         store_data << (8 * store_addr[1:0])});
    if (flush) begin
      model_q.delete();                         // Flush wins over push and pop.
      orphan = model_busy;
    end
  endtask

  task automatic drive_inputs(logic allow_stores);
    logic       next_done;
    logic       next_ready;
    logic       do_flush;
    size_t      size;
    logic [1:0] off;
    int         pick;
    next_done = 1'b0;
    if (resp_pending) begin
      if (resp_wait == 0) begin
        next_done    = 1'b1;
        resp_pending = 1'b0;
      end else begin
        resp_wait--;
      end
    end
    mem_done   <= next_done;
    do_flush   = allow_stores && ($urandom % 60 == 0);
    flush      <= do_flush;
    next_ready = !(model_q.size() == DEPTH && !(model_busy && next_done));
    // No new stores while a flushed write is still out.
    if (allow_stores && !do_flush && !orphan && next_ready && ($urandom % 4 != 0)) begin
      size      = size_t'($urandom % 4);
      off       = pick_offset(size);
      last_addr = {26'h40, 4'($urandom), off};  // Sixteen words, so entries collide.
      store_valid <= 1'b1;
      store_addr  <= last_addr;
      store_size  <= size;
      store_data  <= $urandom;
    end else begin
      store_valid <= 1'b0;
    end
    size = size_t'($urandom % 4);
    off  = pick_offset(size);
    pick = int'($urandom % 10);
    load_size <= size;
    if (pick < 5) load_addr <= {last_addr[31:2], off};  // Recent store word.
    else if (pick < 9) load_addr <= {26'h40, 4'($urandom), off};
    else load_addr <= $urandom;
  endtask

  task automatic step_cycle(logic allow_stores);
    if (saw_write === 1'b1) begin               // Responder arms on each write.
      resp_pending = 1'b1;
      resp_wait    = int'($urandom % 7);
    end
    advance_model();
    drive_inputs(allow_stores);
  endtask

  initial begin
    int wait_cycles;
    void'($urandom(58));
    repeat (4) @(posedge clk);
    rest <= 1'b1;
    for (int c = 0; c < CYCLES; c++) begin
      @(posedge clk);
      step_cycle(1'b1);
    end
    wait_cycles = 0;                            // Let the buffer drain.
    while ((model_q.size() > 0 || model_busy) && wait_cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      step_cycle(1'b0);
      wait_cycles++;
    end
    if (model_q.size() > 0 || model_busy) begin
      $display("Timeout: buffer still held entries after %0d drain cycles", DRAIN_LIMIT);
      timed_out = 1'b1;
    end
    @(negedge clk);
    $display("Errors: %0d, timeouts: %0d, memory writes: %0d", errors, timed_out, writes);
    if (errors == 0 && !timed_out) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
hw/store_buffer_pkg.sv
hw/fifo_sync.sv
hw/store_accept.sv
hw/load_forward.sv
hw/store_drain.sv
hw/store_buffer_top.sv
tb/store_buffer_assertions.sv
tb/store_buffer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= store_buffer_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Done: errors found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
